/* dv/cpuTop_checker.sv */
`timescale 1ns/1ns

module cpuTop_checker (
    input logic Clk,
    input logic rstN,
    input logic dmemRead,
    input logic dmemWrite,
    input logic imemRead,
    input logic halted,
    input logic outputValid,
    input cpuPkg::wordT outputPort
);
    int violationCount = 0;

    dmemExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(dmemRead && dmemWrite))
    else begin
        $error("dmemRead and dmemWrite are high together");
        violationCount++;
    end

    // No fetch once the core has halted
    fetchStopped: assert property (@(posedge Clk) disable iff (!rstN)
        halted |-> !imemRead)
    else begin
        $error("imemRead is high while halted");
        violationCount++;
    end

    outputPulse: assert property (@(posedge Clk) disable iff (!rstN)
        outputValid |=> !outputValid)
    else begin
        $error("outputValid stayed high for two cycles");
        violationCount++;
    end

    outputKnown: assert property (@(posedge Clk) disable iff (!rstN)
        outputValid |-> !$isunknown(outputPort))
    else begin
        $error("outputPort has unknown bits while outputValid is high");
        violationCount++;
    end

endmodule

/* dv/program_golden.mem */
// Word 0 program length N and word 1 output count M, then N program words
// then M expected WWD values in order and the expected retire count (all hex)
0022 0006
// ALU and immediates
4105 42FD F6C0 6112  // r1=0005 r2=FFFD r3=0002 r1=1200
55B4 F7C1 FE82 4181  // r1=12B4 r3=12B2 r2=12B0 r1=FF81
FC1C F903 F01C       // out 12B2  r0=FFB1  out FFB1
// Forwarding at distance one two and three
4101 F580 F6C1 FC1C  // r1=FFB2 r2=FF64 r3=004E out 004E
FE00 F01C            // r0=FFB2 out FFB2
// Store then load with immediate use
6200 8820 7B20 4F01  // r2=0000 [20]=FFB2 r3=FFB2 r3=FFB3
8B21 7921 F41C       // [21]=FFB3 r1=FFB3 out FFB3
// BEQ taken then BNE not taken then JMP to word 30
1701 4501 0701 4502  // BEQ skips the marker  r1=FFB5
901E 4504 F41C       // JMP skips the marker  out FFB5
// HLT and two words that never retire
F01D F41C 4508
// Expected outputs
12B2 FFB1 004E FFB2 FFB3 FFB5
// Expected retire count
001E

/* dv/tbMonitor.sv */
`timescale 1ns/1ns

module tbMonitor (
    input logic Clk,
    input logic rstN,
    input cpuPkg::wordT outputPort,
    input logic outputValid,
    input cpuPkg::wordT numInst,
    input logic halted,
    output logic checksDone,
    output int errorCount
);
    import cpuPkg::*;

    wordT golden [512];
    int progLen;
    int outCount;
    int outSeen;
    int testCount;
    int passCount;
    int haltCycles;

    initial begin
        $readmemh("dv/program_golden.mem", golden);
        progLen = golden[0];
        outCount = golden[1];
        outSeen = 0;
        testCount = 0;
        passCount = 0;
        haltCycles = 0;
        errorCount = 0;
        checksDone = 1'b0;
    end

    task automatic compareOutput();
        wordT expected;
        testCount++;
        if (outSeen >= outCount) begin
            $display("Test %0d failed: more than %0d outputs arrived", testCount, outCount);
            errorCount++;
        end else begin
            expected = golden[2 + progLen + outSeen];
            if (outputPort !== expected) begin
                $display("[ERROR] test %0d outputPort expected 0x%04h actual 0x%04h",
                         testCount, expected, outputPort);
                errorCount++;
            end else begin
                $display("Test %0d passed: outputPort 0x%04h", testCount, outputPort);
                passCount++;
            end
        end
        outSeen++;
    endtask

    task automatic verifyRetireCount();
        wordT expected;
        if (outSeen < outCount) begin
            $display("Only %0d of %0d expected outputs arrived before halt", outSeen, outCount);
            errorCount++;
        end
        testCount++;
        expected = golden[2 + progLen + outCount];
        if (numInst !== expected) begin
            $display("[ERROR] test %0d numInst expected 0x%04h actual 0x%04h",
                     testCount, expected, numInst);
            errorCount++;
        end else begin
            $display("Test %0d passed: numInst 0x%04h", testCount, numInst);
            passCount++;
        end
    endtask

    always @(posedge Clk) begin
        if (rstN && !checksDone) begin
            if (outputValid && halted) begin
                $display("Output 0x%04h appeared after the core halted", outputPort);
                errorCount++;
            end else if (outputValid) begin
                compareOutput();
            end
            if (halted) begin
                haltCycles++;
                // Watch a few cycles for stray outputs
                if (haltCycles == 4) begin
                    verifyRetireCount();
                    $display("Tests run %0d  passed %0d  errors %0d",
                             testCount, passCount, errorCount);
                    checksDone <= 1'b1;
                end
            end
        end
    end

endmodule

/* dv/tbTop.sv */
`timescale 1ns/1ns

module tbTop;
    import cpuPkg::*;

    logic Clk;
    logic rstN;
    wordT imemAddr;
    logic imemRead;
    wordT imemData;
    wordT dmemAddr;
    wordT dmemWData;
    logic dmemRead;
    logic dmemWrite;
    wordT dmemRData;
    wordT outputPort;
    wordT numInst;
    logic outputValid;
    logic halted;
    logic checksDone;
    int errorCount;

    // Golden image holds N, M, the program, expected outputs and retire count
    wordT golden [512];
    wordT imem [256];
    wordT dmem [256];
    int progLen;
    int cycleLimit;
    int cycleCount;

    cpuTop dut0 (
        .Clk(Clk),
        .rstN(rstN),
        .imemAddr(imemAddr),
        .imemRead(imemRead),
        .imemData(imemData),
        .dmemAddr(dmemAddr),
        .dmemWData(dmemWData),
        .dmemRead(dmemRead),
        .dmemWrite(dmemWrite),
        .dmemRData(dmemRData),
        .outputPort(outputPort),
        .numInst(numInst),
        .outputValid(outputValid),
        .halted(halted)
    );

    tbMonitor monitor0 (
        .Clk(Clk),
        .rstN(rstN),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .numInst(numInst),
        .halted(halted),
        .checksDone(checksDone),
        .errorCount(errorCount)
    );

    bind cpuTop cpuTop_checker checker0 (
        .Clk(Clk),
        .rstN(rstN),
        .dmemRead(dmemRead),
        .dmemWrite(dmemWrite),
        .imemRead(imemRead),
        .halted(halted),
        .outputValid(outputValid),
        .outputPort(outputPort)
    );

    initial begin
        Clk = 1'b0;
    end

    always #20 Clk = ~Clk;

    // Both memories answer combinationally while their read strobe is high
    assign imemData = imemRead ? imem[imemAddr[7:0]] : '0;
    assign dmemRData = dmemRead ? dmem[dmemAddr[7:0]] : '0;

    always @(posedge Clk) begin
        if (dmemWrite) begin
            dmem[dmemAddr[7:0]] <= dmemWData;
        end
    end

    initial begin
        rstN = 1'b0;
        cycleCount = 0;
        $readmemh("dv/program_golden.mem", golden);
        progLen = golden[0];
        cycleLimit = 8 * progLen + 50;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = '0;
            imem[i] = (i < progLen) ? golden[i + 2] : '0;
        end

        repeat (3) @(posedge Clk);
        #1;
        rstN = 1'b1;

        while (checksDone !== 1'b1 && cycleCount < cycleLimit) begin
            @(posedge Clk);
            cycleCount++;
        end
        #1;

        if (checksDone !== 1'b1) begin
            $display("Timeout: the core did not halt within %0d cycles", cycleLimit);
            $display("Simulation failed");
        end else if (errorCount == 0 && dut0.checker0.violationCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0] regIdxT;
    typedef logic [3:0] opcodeT;
    typedef logic [5:0] funcT;
    typedef logic [2:0] aluOpT;

    // Opcodes
    localparam opcodeT opBne = 4'd0;
    localparam opcodeT opBeq = 4'd1;
    localparam opcodeT opAdi = 4'd4;
    localparam opcodeT opOri = 4'd5;
    localparam opcodeT opLhi = 4'd6;
    localparam opcodeT opLwd = 4'd7;
    localparam opcodeT opSwd = 4'd8;
    localparam opcodeT opJmp = 4'd9;
    localparam opcodeT opRtype = 4'd15;

    // R-type function codes
    localparam funcT funcAdd = 6'd0;
    localparam funcT funcSub = 6'd1;
    localparam funcT funcAnd = 6'd2;
    localparam funcT funcOrr = 6'd3;
    localparam funcT funcWwd = 6'd28;
    localparam funcT funcHlt = 6'd29;

    localparam aluOpT aluAdd = 3'd0;
    localparam aluOpT aluSub = 3'd1;
    localparam aluOpT aluAnd = 3'd2;
    localparam aluOpT aluOr = 3'd3;
    localparam aluOpT aluLhi = 3'd4;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic aluSrcImm;
        logic isBranch;
        logic branchOnEqual;
        logic isWwd;
        logic isHalt;
        aluOpT aluOp;
    } ctrlT;

    // Control left after execute
    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic isWwd;
        logic isHalt;
    } exMemCtrlT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic isWwd;
        logic isHalt;
    } memWbCtrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic valid;
        wordT pc;
        ctrlT ctrl;
        wordT readData1;
        wordT readData2;
        regIdxT rs;
        regIdxT rt;
        regIdxT dest;
        wordT imm;
    } idExT;

    typedef struct packed {
        logic valid;
        exMemCtrlT ctrl;
        wordT aluResult;
        wordT storeData;
        regIdxT dest;
    } exMemT;

    typedef struct packed {
        logic valid;
        memWbCtrlT ctrl;
        wordT aluResult;
        wordT loadData;
        regIdxT dest;
    } memWbT;

    typedef struct packed {
        logic writeEnable;
        regIdxT writeIdx;
        wordT writeData;
    } wbBusT;

endpackage

/* logic/cpuTop.sv */
`timescale 1ns/1ns

module cpuTop (
    input logic Clk,
    input logic rstN,
    output cpuPkg::wordT imemAddr,
    output logic imemRead,
    input cpuPkg::wordT imemData,
    output cpuPkg::wordT dmemAddr,
    output cpuPkg::wordT dmemWData,
    output logic dmemRead,
    output logic dmemWrite,
    input cpuPkg::wordT dmemRData,
    output cpuPkg::wordT outputPort,
    output cpuPkg::wordT numInst,
    output logic outputValid,
    output logic halted
);
    import cpuPkg::*;

    ifIdT ifId;
    idExT idEx;
    exMemT exMem;
    wbBusT wbBus;
    logic stall;
    logic jumpValid;
    wordT jumpTarget;
    logic branchTaken;
    wordT branchTarget;

    fetchStage fetch0 (
        .Clk(Clk),
        .rstN(rstN),
        .stall(stall),
        .jumpValid(jumpValid),
        .branchTaken(branchTaken),
        .halted(halted),
        .jumpTarget(jumpTarget),
        .branchTarget(branchTarget),
        .imemData(imemData),
        .imemAddr(imemAddr),
        .imemRead(imemRead),
        .ifId(ifId)
    );

    decodeStage decode0 (
        .Clk(Clk),
        .rstN(rstN),
        .ifId(ifId),
        .flush(branchTaken),
        .wbBus(wbBus),
        .stall(stall),
        .jumpValid(jumpValid),
        .jumpTarget(jumpTarget),
        .idEx(idEx)
    );

    executeStage execute0 (
        .Clk(Clk),
        .rstN(rstN),
        .idEx(idEx),
        .wbBus(wbBus),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .exMem(exMem)
    );

    memWbStage memWb0 (
        .Clk(Clk),
        .rstN(rstN),
        .exMem(exMem),
        .dmemRData(dmemRData),
        .dmemAddr(dmemAddr),
        .dmemWData(dmemWData),
        .dmemRead(dmemRead),
        .dmemWrite(dmemWrite),
        .wbBus(wbBus),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .numInst(numInst),
        .halted(halted)
    );

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ns

module decodeStage (
    input logic Clk,
    input logic rstN,
    input cpuPkg::ifIdT ifId,
    input logic flush,
    input cpuPkg::wbBusT wbBus,
    output logic stall,
    output logic jumpValid,
    output cpuPkg::wordT jumpTarget,
    output cpuPkg::idExT idEx
);
    import cpuPkg::*;

    opcodeT opcode;
    funcT func;
    regIdxT rs;
    regIdxT rt;
    regIdxT rd;
    logic [7:0] imm8;
    ctrlT ctrl;
    wordT immExt;
    regIdxT dest;
    logic usesRs;
    logic usesRt;
    wordT regFile [4];
    wordT readData1;
    wordT readData2;

    assign opcode = ifId.instr[15:12];
    assign rs = ifId.instr[11:10];
    assign rt = ifId.instr[9:8];
    assign rd = ifId.instr[7:6];
    assign func = ifId.instr[5:0];
    assign imm8 = ifId.instr[7:0];

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        case (opcode)
            opBne: begin
                ctrl.isBranch = 1'b1;
            end
            opBeq: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchOnEqual = 1'b1;
            end
            opAdi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = aluOr;
            end
            opLhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = aluLhi;
            end
            opLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSwd: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opRtype: begin
                case (func)
                    funcAdd: ctrl.regWrite = 1'b1;
                    funcSub: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluSub;
                    end
                    funcAnd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluAnd;
                    end
                    funcOrr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluOr;
                    end
                    funcWwd: ctrl.isWwd = 1'b1;
                    funcHlt: ctrl.isHalt = 1'b1;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            default: ctrl.aluOp = aluAdd;
        endcase
    end

    // ORI and LHI take the byte unsigned
    assign immExt = (opcode == opOri || opcode == opLhi) ? {8'h00, imm8} : {{8{imm8[7]}}, imm8};
    assign dest = (opcode == opRtype) ? rd : rt;

    assign usesRs = (opcode != opJmp) && (opcode != opLhi) &&
                    !(opcode == opRtype && func == funcHlt);
    assign usesRt = (opcode == opBne) || (opcode == opBeq) || (opcode == opSwd) ||
                    (opcode == opRtype && func <= funcOrr);

    // Load-use hazard against the entry now in execute
    assign stall = ifId.valid && idEx.valid && idEx.ctrl.memRead &&
                   ((usesRs && rs == idEx.dest) || (usesRt && rt == idEx.dest));

    assign jumpValid = ifId.valid && !flush && opcode == opJmp;
    assign jumpTarget = {ifId.pc[15:12], ifId.instr[11:0]};

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbBus.writeEnable) begin
            regFile[wbBus.writeIdx] <= wbBus.writeData;
        end
    end

    // Same-cycle write passes straight through
    assign readData1 = (wbBus.writeEnable && wbBus.writeIdx == rs) ? wbBus.writeData : regFile[rs];
    assign readData2 = (wbBus.writeEnable && wbBus.writeIdx == rt) ? wbBus.writeData : regFile[rt];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid <= ifId.valid && !flush && !stall;
            idEx.pc <= ifId.pc;
            idEx.ctrl <= ctrl;
            idEx.readData1 <= readData1;
            idEx.readData2 <= readData2;
            idEx.rs <= rs;
            idEx.rt <= rt;
            idEx.dest <= dest;
            idEx.imm <= immExt;
        end
    end

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ns

module executeStage (
    input logic Clk,
    input logic rstN,
    input cpuPkg::idExT idEx,
    input cpuPkg::wbBusT wbBus,
    output logic branchTaken,
    output cpuPkg::wordT branchTarget,
    output cpuPkg::exMemT exMem
);
    import cpuPkg::*;

    logic memFwdA;
    logic memFwdB;
    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluOut;
    wordT result;
    logic operandsEqual;

    // Loads are not taken from the memory stage
    assign memFwdA = exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memToReg &&
                     exMem.dest == idEx.rs;
    assign memFwdB = exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memToReg &&
                     exMem.dest == idEx.rt;

    always_comb begin
        if (memFwdA) begin
            opA = exMem.aluResult;
        end else if (wbBus.writeEnable && wbBus.writeIdx == idEx.rs) begin
            opA = wbBus.writeData;
        end else begin
            opA = idEx.readData1;
        end
    end

    always_comb begin
        if (memFwdB) begin
            opB = exMem.aluResult;
        end else if (wbBus.writeEnable && wbBus.writeIdx == idEx.rt) begin
            opB = wbBus.writeData;
        end else begin
            opB = idEx.readData2;
        end
    end

    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub: aluOut = opA - aluB;
            aluAnd: aluOut = opA & aluB;
            aluOr: aluOut = opA | aluB;
            aluLhi: aluOut = {aluB[7:0], 8'h00};
            default: aluOut = opA + aluB;
        endcase
    end

    // WWD sends rs out unchanged
    assign result = idEx.ctrl.isWwd ? opA : aluOut;

    assign operandsEqual = (opA == opB);
    assign branchTaken = idEx.valid && idEx.ctrl.isBranch &&
                         (operandsEqual == idEx.ctrl.branchOnEqual);
    assign branchTarget = idEx.pc + 16'd1 + idEx.imm;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.ctrl.regWrite <= idEx.ctrl.regWrite;
            exMem.ctrl.memToReg <= idEx.ctrl.memToReg;
            exMem.ctrl.memRead <= idEx.ctrl.memRead;
            exMem.ctrl.memWrite <= idEx.ctrl.memWrite;
            exMem.ctrl.isWwd <= idEx.ctrl.isWwd;
            exMem.ctrl.isHalt <= idEx.ctrl.isHalt;
            exMem.aluResult <= result;
            exMem.storeData <= opB;
            exMem.dest <= idEx.dest;
        end
    end

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/1ns

module fetchStage (
    input logic Clk,
    input logic rstN,
    input logic stall,
    input logic jumpValid,
    input logic branchTaken,
    input logic halted,
    input cpuPkg::wordT jumpTarget,
    input cpuPkg::wordT branchTarget,
    input cpuPkg::wordT imemData,
    output cpuPkg::wordT imemAddr,
    output logic imemRead,
    output cpuPkg::ifIdT ifId
);
    import cpuPkg::*;

    wordT pc;
    wordT nextPc;

    // Branch from execute wins over jump from decode
    always_comb begin
        if (branchTaken) begin
            nextPc = branchTarget;
        end else if (jumpValid) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = pc + 16'd1;
        end
    end

    assign imemAddr = pc;
    assign imemRead = !halted;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (branchTaken || jumpValid) begin
            pc <= nextPc;
        end else if (!stall && !halted) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ifId.valid <= 1'b0;
        end else if (branchTaken || jumpValid) begin
            // Drop the word fetched down the wrong path
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId.valid <= !halted;
            ifId.pc <= pc;
            ifId.instr <= imemData;
        end
    end

endmodule

/* logic/memWbStage.sv */
`timescale 1ns/1ns

module memWbStage (
    input logic Clk,
    input logic rstN,
    input cpuPkg::exMemT exMem,
    input cpuPkg::wordT dmemRData,
    output cpuPkg::wordT dmemAddr,
    output cpuPkg::wordT dmemWData,
    output logic dmemRead,
    output logic dmemWrite,
    output cpuPkg::wbBusT wbBus,
    output cpuPkg::wordT outputPort,
    output logic outputValid,
    output cpuPkg::wordT numInst,
    output logic halted
);
    import cpuPkg::*;

    memWbT memWb;
    logic haltPending;
    logic retire;

    // Anything younger than a retiring HLT must not touch memory
    assign haltPending = halted || (memWb.valid && memWb.ctrl.isHalt);

    assign dmemAddr = exMem.aluResult;
    assign dmemWData = exMem.storeData;
    assign dmemRead = exMem.valid && exMem.ctrl.memRead && !haltPending;
    assign dmemWrite = exMem.valid && exMem.ctrl.memWrite && !haltPending;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            memWb.valid <= 1'b0;
        end else begin
            memWb.valid <= exMem.valid;
            memWb.ctrl.regWrite <= exMem.ctrl.regWrite;
            memWb.ctrl.memToReg <= exMem.ctrl.memToReg;
            memWb.ctrl.isWwd <= exMem.ctrl.isWwd;
            memWb.ctrl.isHalt <= exMem.ctrl.isHalt;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData <= dmemRData;
            memWb.dest <= exMem.dest;
        end
    end

    assign retire = memWb.valid && !halted;

    assign wbBus.writeEnable = retire && memWb.ctrl.regWrite;
    assign wbBus.writeIdx = memWb.dest;
    assign wbBus.writeData = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluResult;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            numInst <= '0;
            outputValid <= 1'b0;
            halted <= 1'b0;
        end else begin
            outputValid <= retire && memWb.ctrl.isWwd;
            if (retire) begin
                numInst <= numInst + 16'd1;
            end
            if (retire && memWb.ctrl.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    // Output word held until the next WWD
    always_ff @(posedge Clk) begin
        if (retire && memWb.ctrl.isWwd) begin
            outputPort <= memWb.aluResult;
        end
    end

endmodule

/* tb.f */
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/cpuTop.sv
dv/cpuTop_checker.sv
dv/tbMonitor.sv
dv/tbTop.sv
